// ==== mod_vga.f ====
common/vga_pkg.sv
vga/vga_timing.sv
vga/vga_line_buffer.sv
vga/vga_pixel_out.sv
rtl/vga_bus_regs.sv
rtl/mod_vga.sv
verification/tb_clock_gen.sv
verification/mod_vga_properties.sv
verification/mod_vga_tb.sv

// ==== verification/mod_vga_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mod_vga_tb;

	localparam int H_ACT = 16;
	localparam int H_FP = 2;
	localparam int H_PW = 4;
	localparam int H_BP = 3;
	localparam int V_ACT = 6;
	localparam int V_FP = 1;
	localparam int V_PW = 2;
	localparam int V_BP = 1;
	localparam int H_TOT = H_PW + H_BP + H_ACT + H_FP;
	localparam int V_TOT = V_PW + V_BP + V_ACT + V_FP; // in lines
	localparam int BUS_TIMEOUT = 20;
	localparam int WAIT_TIMEOUT = 3 * H_TOT * V_TOT;

	logic clk;
	logic rst;
	vga_pkg::wb_req_t wb_req;
	vga_pkg::wb_rsp_t wb_rsp;
	logic [7:0] rgb;
	logic hs;
	logic vs;

	integer seed = 32'h5e0a_3fe1;
	int errors = 0;
	int checks = 0;
	int pix_checks = 0;
	logic [7:0] shadow [H_ACT]; // what the buffer should hold
	bit exp_enable = 1'b0;
	int exp_scroll = 0;
	string cur_test = "none";

	// scan position tracking
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;
	int hpos = 0;
	int line_idx = 0;
	bit frame_known = 1'b0;
	int frame_cnt = 0;
	int check_frame = -1;
	logic [7:0] exp_pix;

	tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(5)) clk0 (.clk(clk), .rst(rst));

	mod_vga #(
		.H_ACTIVE(H_ACT), .H_FRONTPORCH(H_FP), .H_PULSEWIDTH(H_PW), .H_BACKPORCH(H_BP),
		.V_ACTIVE(V_ACT), .V_FRONTPORCH(V_FP), .V_PULSEWIDTH(V_PW), .V_BACKPORCH(V_BP)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.rgb(rgb),
		.hs(hs),
		.vs(vs)
	);

	// pixel seen at position x of a visible line
	function automatic logic [7:0] expected_rgb(input int x, input int scroll, input bit en,
			input logic [7:0] line [H_ACT]);
		if (!en)
			return 8'h00;
		return line[(x + scroll) % H_ACT];
	endfunction

	function automatic string reg_name(input vga_pkg::vga_reg_e r);
		return r.name();
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] data,
			output logic [31:0] rdata);
		int timer;
		bit got;
		timer = 0;
		got = 1'b0;
		rdata = '0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: data};
		while (!got && timer < BUS_TIMEOUT) begin
			@(posedge clk);
			if (wb_rsp.ack)
				got = 1'b1;
			else
				timer++;
		end
		if (got)
			rdata = wb_rsp.dat_r;
		else begin
			errors++;
			$display("bus access to address 0x%0h got no ack in time", adr);
		end
		wb_req <= '0;
	endtask

	task automatic bus_write(input logic [11:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b1, adr, data, unused);
	endtask

	task automatic read_expect(input string name, input logic [11:0] adr,
			input logic [31:0] expected);
		logic [31:0] rdata;
		bus_access(1'b0, adr, '0, rdata);
		check_value(name, expected, rdata);
	endtask

	task automatic write_pixel(input int idx, input logic [31:0] val);
		bus_write(vga_pkg::ADDR_PIXEL_BASE + 12'(4 * idx), val);
		shadow[idx] = val[7:0]; // only the low byte is kept
	endtask

	// waits until hs or vs reaches level and returns the clocks spent
	task automatic wait_sync(input bit use_vs, input logic level, output int cycles);
		cycles = 0;
		while ((use_vs ? vs : hs) !== level && cycles < WAIT_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if ((use_vs ? vs : hs) !== level) begin
			errors++;
			$display("sync signal did not reach the expected level in time");
		end
	endtask

	// the whole frame after the current one is compared pixel by pixel
	task automatic check_next_frame(input string name);
		int timer;
		timer = 0;
		cur_test = name;
		check_frame = frame_cnt + 1;
		while (frame_cnt <= check_frame && timer < WAIT_TIMEOUT) begin
			@(posedge clk);
			timer++;
		end
		if (frame_cnt <= check_frame) begin
			errors++;
			$display("frame did not finish in time during %s", name);
		end
		check_frame = -1;
	endtask

	// checker sampling at the falling edge where outputs are settled
	always @(negedge clk) begin
		if (rst) begin
			prev_hs = 1'b1;
			prev_vs = 1'b1;
			frame_known = 1'b0;
		end else begin
			hpos = (!prev_hs && hs) ? 0 : hpos + 1;
			if (prev_hs && !hs)
				line_idx++;
			if (!prev_vs && vs) begin // first back porch line
				line_idx = 0;
				frame_known = 1'b1;
			end
			if (prev_vs && !vs)
				frame_cnt++;
			if (frame_known && frame_cnt == check_frame) begin
				exp_pix = 8'h00;
				if (line_idx >= V_BP && line_idx < V_BP + V_ACT && hs
						&& hpos >= H_BP && hpos < H_BP + H_ACT)
					exp_pix = expected_rgb(hpos - H_BP, exp_scroll, exp_enable, shadow);
				check_value($sformatf("%s line %0d pos %0d", cur_test, line_idx, hpos),
					exp_pix, rgb);
				pix_checks++;
			end
			prev_hs = hs;
			prev_vs = vs;
		end
	end

	initial begin
		int low;
		int high;
		int hs_low;
		int timer;
		wb_req = '0;
		timer = 0;
		while (rst !== 1'b0 && timer < 100) begin
			@(posedge clk);
			timer++;
		end
		if (rst !== 1'b0) begin
			errors++;
			$display("reset was never released");
		end

		read_expect(reg_name(vga_pkg::REG_CTRL), vga_pkg::ADDR_CTRL, 32'd0);
		read_expect(reg_name(vga_pkg::REG_SCROLL), vga_pkg::ADDR_SCROLL, 32'd0);
		bus_write(vga_pkg::ADDR_CTRL, 32'h0000_00a5);
		read_expect(reg_name(vga_pkg::REG_CTRL), vga_pkg::ADDR_CTRL, 32'd1); // bit 0 only
		bus_write(vga_pkg::ADDR_SCROLL, 32'd37);
		read_expect(reg_name(vga_pkg::REG_SCROLL), vga_pkg::ADDR_SCROLL, 32'(37 % H_ACT));
		read_expect(reg_name(vga_pkg::REG_NONE), 12'h008, 32'd0);
		write_pixel(0, 32'h0000_00c3); // a stored pixel must not show up on the bus
		read_expect(reg_name(vga_pkg::REG_PIXEL), vga_pkg::ADDR_PIXEL_BASE, 32'd0);
		bus_write(vga_pkg::ADDR_CTRL, 32'd0);
		bus_write(vga_pkg::ADDR_SCROLL, 32'd0);

		// line and frame geometry measured from falling edges
		wait_sync(1'b0, 1'b1, low);
		wait_sync(1'b0, 1'b0, low);
		wait_sync(1'b0, 1'b1, low);
		wait_sync(1'b0, 1'b0, high);
		check_value("hsync low clocks", H_PW, low);
		check_value("hsync period", H_TOT, low + high);
		wait_sync(1'b1, 1'b1, low);
		wait_sync(1'b1, 1'b0, low);
		wait_sync(1'b0, 1'b1, hs_low); // vs falls on the first clock of the hs pulse
		check_value("vsync edge on hsync fall", H_PW, hs_low);
		wait_sync(1'b1, 1'b1, low);
		low += hs_low;
		wait_sync(1'b1, 1'b0, high);
		check_value("vsync low lines", V_PW, low / H_TOT);
		check_value("vsync low remainder", 0, low % H_TOT);
		check_value("vsync period lines", V_TOT, (low + high) / H_TOT);
		check_value("vsync period remainder", 0, (low + high) % H_TOT);

		for (int i = 0; i < H_ACT; i++)
			write_pixel(i, $random(seed));
		check_next_frame("disabled");

		bus_write(vga_pkg::ADDR_CTRL, 32'd1);
		exp_enable = 1'b1;
		check_next_frame("enabled");

		bus_write(vga_pkg::ADDR_SCROLL, 32'd27);
		exp_scroll = 27 % H_ACT;
		check_next_frame("scrolled");

		write_pixel(0, $random(seed));
		write_pixel(4, $random(seed));
		write_pixel(9, $random(seed));
		write_pixel(15, $random(seed));
		check_next_frame("pixel_update");

		errors += dut0.props0.fail_count;
		$display("checks %0d, pixel checks %0d, errors %0d (assertion failures %0d)",
			checks, pix_checks, errors, dut0.props0.fail_count);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/mod_vga_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// handshake and sync checks, bound into the top level
module mod_vga_properties #(
	parameter int H_PULSEWIDTH = 96
) (
	input logic clk,
	input logic rst,
	input vga_pkg::wb_req_t wb_req,
	input vga_pkg::wb_rsp_t wb_rsp,
	input logic hs
);

	int fail_count = 0; // read by the testbench at the end
	logic req_pending;

	assign req_pending = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

	ack_follows_req: assert property (@(posedge clk) disable iff (rst)
		req_pending |=> wb_rsp.ack)
		else begin
			$error("ack missing one cycle after a request");
			fail_count++;
		end

	ack_has_req: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack |-> $past(req_pending))
		else begin
			$error("ack without a preceding request");
			fail_count++;
		end

	ack_single: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			$error("ack held for more than one cycle");
			fail_count++;
		end

	dat_r_idle: assert property (@(posedge clk) disable iff (rst)
		!wb_rsp.ack |-> wb_rsp.dat_r == '0)
		else begin
			$error("read data not zero outside ack");
			fail_count++;
		end

	// sync pulse is exactly H_PULSEWIDTH clocks
	hs_pulse: assert property (@(posedge clk) disable iff (rst)
		$fell(hs) |-> (!hs) [*H_PULSEWIDTH] ##1 hs)
		else begin
			$error("hs pulse width wrong");
			fail_count++;
		end

endmodule

bind mod_vga mod_vga_properties #(.H_PULSEWIDTH(H_PULSEWIDTH)) props0 (
	.clk(clk),
	.rst(rst),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.hs(hs)
);

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running clock plus a synchronous reset held for the first few cycles
module tb_clock_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0; // released on a rising edge like any other input
	end

endmodule

`default_nettype wire

// ==== rtl/mod_vga.sv ====
`timescale 1ns/1ps
`default_nettype none

// vga peripheral: wishbone registers, one-line buffer, sync generator
module mod_vga #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONTPORCH = 16,
	parameter int H_PULSEWIDTH = 96,
	parameter int H_BACKPORCH = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONTPORCH = 10,
	parameter int V_PULSEWIDTH = 2,
	parameter int V_BACKPORCH = 29
) (
	input logic clk,
	input logic rst,
	input vga_pkg::wb_req_t wb_req,
	output vga_pkg::wb_rsp_t wb_rsp,
	output logic [7:0] rgb,
	output logic hs,
	output logic vs
);

	vga_pkg::vga_timing_t timing; // raster position, registered in timing0
	vga_pkg::pix_wr_t pix_wr;
	logic enable;
	logic [10:0] scroll;
	logic [7:0] pixel; // buffer data, one cycle behind timing

	vga_bus_regs #(.H_ACTIVE(H_ACTIVE)) regs0 (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.enable(enable),
		.scroll(scroll),
		.pix_wr(pix_wr)
	);

	vga_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONTPORCH(H_FRONTPORCH),
		.H_PULSEWIDTH(H_PULSEWIDTH),
		.H_BACKPORCH(H_BACKPORCH),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONTPORCH(V_FRONTPORCH),
		.V_PULSEWIDTH(V_PULSEWIDTH),
		.V_BACKPORCH(V_BACKPORCH)
	) timing0 (
		.clk(clk),
		.rst(rst),
		.timing(timing)
	);

	vga_line_buffer #(.H_ACTIVE(H_ACTIVE)) line0 (
		.clk(clk),
		.pix_wr(pix_wr),
		.scroll(scroll),
		.timing(timing),
		.pixel(pixel)
	);

	vga_pixel_out pix0 (
		.clk(clk),
		.rst(rst),
		.timing(timing),
		.pixel(pixel),
		.enable(enable),
		.rgb(rgb),
		.hs(hs),
		.vs(vs)
	);

endmodule

`default_nettype wire

// ==== rtl/vga_bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// wishbone classic slave, one wait state, for ctrl / scroll / pixel words
module vga_bus_regs #(
	parameter int H_ACTIVE = 640
) (
	input logic clk,
	input logic rst,
	input vga_pkg::wb_req_t wb_req,
	output vga_pkg::wb_rsp_t wb_rsp,
	output logic enable,
	output logic [10:0] scroll,
	output vga_pkg::pix_wr_t pix_wr
);

	vga_pkg::vga_reg_e reg_sel;
	logic ack_q;
	logic access; // new request, ack not yet given
	logic [11:0] pix_off;
	logic [10:0] pix_idx;
	logic [31:0] rd_mux;

	// pixel write pulse, lines up with ack
	logic pix_en_q;
	logic [10:0] pix_addr_q;
	logic [7:0] pix_data_q;

	assign access = wb_req.cyc && wb_req.stb && !ack_q;

	/*
	 * the pixel window starts at ADDR_PIXEL_BASE, one word per pixel.
	 * with a 12-bit address it covers 512 words, so only that many
	 * pixels of a wider line are reachable from the bus
	 */
	assign pix_off = wb_req.adr - vga_pkg::ADDR_PIXEL_BASE;
	assign pix_idx = {1'b0, pix_off[11:2]};

	always_comb begin
		reg_sel = vga_pkg::REG_NONE;
		if (wb_req.adr == vga_pkg::ADDR_CTRL)
			reg_sel = vga_pkg::REG_CTRL;
		else if (wb_req.adr == vga_pkg::ADDR_SCROLL)
			reg_sel = vga_pkg::REG_SCROLL;
		else if (wb_req.adr >= vga_pkg::ADDR_PIXEL_BASE && pix_idx < 11'(H_ACTIVE))
			reg_sel = vga_pkg::REG_PIXEL;
	end

	// ack one cycle after the request, for exactly one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			enable <= 1'b0;
			scroll <= '0;
			pix_en_q <= 1'b0;
		end else begin
			ack_q <= access;
			pix_en_q <= access && wb_req.we && reg_sel == vga_pkg::REG_PIXEL;
			if (access && wb_req.we) begin
				case (reg_sel)
					vga_pkg::REG_CTRL: enable <= wb_req.dat_w[0];
					vga_pkg::REG_SCROLL: scroll <= 11'(wb_req.dat_w % 32'(H_ACTIVE));
					default: ; // pixels go out through pix_wr
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			pix_addr_q <= pix_idx;
			pix_data_q <= wb_req.dat_w[7:0]; // low byte only
		end
	end

	assign pix_wr = '{en: pix_en_q, addr: pix_addr_q, data: pix_data_q};

	// read side; request is still held while ack is high
	always_comb begin
		case (reg_sel)
			vga_pkg::REG_CTRL: rd_mux = {31'd0, enable};
			vga_pkg::REG_SCROLL: rd_mux = {21'd0, scroll};
			default: rd_mux = '0; // pixel reads are not supported
		endcase
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat_r = (ack_q && !wb_req.we) ? rd_mux : '0;

endmodule

`default_nettype wire

// ==== vga/vga_pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

// output stage: syncs and colour leave together, two clocks after timing
module vga_pixel_out (
	input logic clk,
	input logic rst,
	input vga_pkg::vga_timing_t timing,
	input logic [7:0] pixel,
	input logic enable,
	output logic [7:0] rgb,
	output logic hs,
	output logic vs
);

	vga_pkg::vga_timing_t timing_d; // matches the buffer read latency

	always_ff @(posedge clk) begin
		if (rst) begin
			timing_d <= '{hs: 1'b1, vs: 1'b1, blank: 1'b1, hcount: '0, vcount: '0};
			rgb <= '0;
			hs <= 1'b1; // syncs idle high
			vs <= 1'b1;
		end else begin
			timing_d <= timing;
			// black in the porches and while the display is off
			if (!timing_d.blank && enable)
				rgb <= pixel;
			else
				rgb <= '0;
			hs <= timing_d.hs;
			vs <= timing_d.vs;
		end
	end

endmodule

`default_nettype wire

// ==== vga/vga_line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// single scan line of 8-bit pixels, shown on every visible line
module vga_line_buffer #(
	parameter int H_ACTIVE = 640
) (
	input logic clk,
	input vga_pkg::pix_wr_t pix_wr,
	input logic [10:0] scroll,
	input vga_pkg::vga_timing_t timing,
	output logic [7:0] pixel
);

	localparam int AW = $clog2(H_ACTIVE);

	logic [7:0] mem [H_ACTIVE];
	logic [11:0] rd_sum;
	logic [11:0] rd_idx;

	// both terms are below H_ACTIVE, so one subtract does the wrap
	assign rd_sum = {1'b0, timing.hcount} + {1'b0, scroll};
	assign rd_idx = (rd_sum >= 12'(H_ACTIVE)) ? rd_sum - 12'(H_ACTIVE) : rd_sum;

	always_ff @(posedge clk) begin
		if (pix_wr.en)
			mem[pix_wr.addr[AW-1:0]] <= pix_wr.data;
		pixel <= mem[rd_idx[AW-1:0]]; // one cycle behind timing
	end

endmodule

`default_nettype wire

// ==== vga/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

// line and frame counters, sync pulses first, then back porch, active, front porch
module vga_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONTPORCH = 16,
	parameter int H_PULSEWIDTH = 96,
	parameter int H_BACKPORCH = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONTPORCH = 10,
	parameter int V_PULSEWIDTH = 2,
	parameter int V_BACKPORCH = 29
) (
	input logic clk,
	input logic rst,
	output vga_pkg::vga_timing_t timing
);

	localparam int H_START = H_PULSEWIDTH + H_BACKPORCH; // first visible clock
	localparam int H_END = H_START + H_ACTIVE;
	localparam int H_TOTAL = H_END + H_FRONTPORCH;
	localparam int V_START = V_PULSEWIDTH + V_BACKPORCH;
	localparam int V_END = V_START + V_ACTIVE;
	localparam int V_TOTAL = V_END + V_FRONTPORCH;

	logic [10:0] hcounter, vcounter;
	logic [10:0] h_next, v_next;

	// raster position for a given pair of counter values
	function automatic vga_pkg::vga_timing_t decode(input logic [10:0] h, input logic [10:0] v);
		vga_pkg::vga_timing_t t;
		logic h_act;
		logic v_act;
		h_act = (h >= 11'(H_START)) && (h < 11'(H_END));
		v_act = (v >= 11'(V_START)) && (v < 11'(V_END));
		t.hs = (h >= 11'(H_PULSEWIDTH)); // low during the pulse
		t.vs = (v >= 11'(V_PULSEWIDTH));
		t.blank = !(h_act && v_act);
		t.hcount = h_act ? h - 11'(H_START) : '0;
		t.vcount = v_act ? v - 11'(V_START) : '0;
		return t;
	endfunction

	// vertical steps only when the line wraps, i.e. on the hs falling edge
	always_comb begin
		h_next = hcounter + 11'd1;
		v_next = vcounter;
		if (hcounter == 11'(H_TOTAL - 1)) begin
			h_next = '0;
			if (vcounter == 11'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = vcounter + 11'd1;
		end
	end

	// timing struct is always the decode of the counters it is stored with
	always_ff @(posedge clk) begin
		if (rst) begin
			hcounter <= '0;
			vcounter <= '0;
			timing <= decode(11'd0, 11'd0);
		end else begin
			hcounter <= h_next;
			vcounter <= v_next;
			timing <= decode(h_next, v_next);
		end
	end

endmodule

`default_nettype wire

// ==== common/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

	// bus geometry
	localparam int WB_ADR_W = 12;
	localparam int WB_DAT_W = 32;
	localparam int COORD_W = 11; // enough for 2047 clocks or lines

	// register map, byte offsets inside the peripheral window
	localparam logic [WB_ADR_W-1:0] ADDR_CTRL = 12'h000; // bit 0 is display enable
	localparam logic [WB_ADR_W-1:0] ADDR_SCROLL = 12'h004; // horizontal scroll in pixels

	// one word per pixel; only the low byte is stored
	localparam logic [WB_ADR_W-1:0] ADDR_PIXEL_BASE = 12'h800;

	// decoded target of a bus access
	typedef enum logic [1:0] {
		REG_CTRL,
		REG_SCROLL,
		REG_PIXEL,
		REG_NONE
	} vga_reg_e;

	// request from the wishbone master
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat_w;
	} wb_req_t;

	// response back to the master
	typedef struct packed {
		logic ack;
		logic [WB_DAT_W-1:0] dat_r;
	} wb_rsp_t;

	/*
	 * raster position as seen by the pixel path
	 * hcount and vcount count from the first visible pixel / line
	 * and sit at zero outside the active area
	 */
	typedef struct packed {
		logic hs; // active low
		logic vs; // active low
		logic blank;
		logic [COORD_W-1:0] hcount;
		logic [COORD_W-1:0] vcount;
	} vga_timing_t;

	// single write into the line buffer
	typedef struct packed {
		logic en;
		logic [COORD_W-1:0] addr; // pixel index within the line
		logic [7:0] data; // rgb 3-3-2
	} pix_wr_t;

endpackage

`default_nettype wire
